// File: all.f
hw/core_evt_pkg.sv
hw/rvfi_trace_pkg.sv
hw/trace_stage_track.sv
hw/trace_retire_fmt.sv
hw/trace_top.sv
sim/trace_assert.sv
sim/trace_tb.sv

// File: hw/core_evt_pkg.sv
package core_evt_pkg;

  //////////////////////////////
  // Pipeline geometry
  //////////////////////////////

  // The traced core is a plain four stage in-order pipeline
  localparam int NUM_STAGES = 4;

  // Indices into the per-stage tracking arrays
  // IF holds the youngest slot and WB the oldest one
  localparam int STAGE_IF = 0;
  localparam int STAGE_ID = 1;
  localparam int STAGE_EX = 2;
  localparam int STAGE_WB = 3;

  //////////////////////////////
  // Cause encodings
  //////////////////////////////

  // Exception and interrupt causes share one 6 bit code space
  localparam int EXC_CAUSE_W = 6;

  // Debug entry cause as it appears in dcsr.cause
  localparam int DBG_CAUSE_W = 3;

  typedef logic [EXC_CAUSE_W-1:0] exc_cause_t;
  typedef logic [DBG_CAUSE_W-1:0] dbg_cause_t;

  // Debug cause codes
  // Code 2 (trigger) is never produced by this core
  localparam dbg_cause_t DBG_CAUSE_NONE    = 3'd0;
  localparam dbg_cause_t DBG_CAUSE_EBREAK  = 3'd1;
  localparam dbg_cause_t DBG_CAUSE_HALTREQ = 3'd3;
  localparam dbg_cause_t DBG_CAUSE_STEP    = 3'd4;

endpackage

// File: hw/rvfi_trace_pkg.sv
package rvfi_trace_pkg;

  //////////////////////////////
  // Record field widths
  //////////////////////////////

  // The interrupt field cause is wider than the core cause
  // Upper bits are always zero in this core
  localparam int INTR_CAUSE_W = 11;

  // Trap fields reuse the core cause widths so they cannot drift apart
  localparam int TRAP_CAUSE_W     = core_evt_pkg::EXC_CAUSE_W;
  localparam int TRAP_DBG_CAUSE_W = core_evt_pkg::DBG_CAUSE_W;

  // The dbg field of a record carries a dcsr.cause code
  localparam int DBG_FIELD_W = core_evt_pkg::DBG_CAUSE_W;

  // Number of single bit flags in the trap field
  localparam int TRAP_FIELDS = 3;

  // Bit positions inside the trap flag vector
  localparam int TRAP_BIT_TRAP = 0;
  localparam int TRAP_BIT_EXC  = 1;
  localparam int TRAP_BIT_DBG  = 2;

  //////////////////////////////
  // Record field types
  //////////////////////////////

  typedef logic [INTR_CAUSE_W-1:0]     intr_cause_t;
  typedef logic [TRAP_CAUSE_W-1:0]     trap_cause_t;
  typedef logic [TRAP_DBG_CAUSE_W-1:0] trap_dbg_cause_t;
  typedef logic [DBG_FIELD_W-1:0]      dbg_field_t;
  typedef logic [TRAP_FIELDS-1:0]      trap_flags_t;

  // Widen a core cause into the interrupt field of a record
  // Zero extension only, the core has no causes above bit 5
  function automatic intr_cause_t intr_cause_from_exc(input core_evt_pkg::exc_cause_t cause);
    return {{(INTR_CAUSE_W - core_evt_pkg::EXC_CAUSE_W){1'b0}}, cause};
  endfunction

endpackage

// File: hw/trace_retire_fmt.sv
module trace_retire_fmt (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Retiring instruction and its marker
  input  logic                            wb_retire_i,
  input  logic                            wb_irq_i,
  input  core_evt_pkg::exc_cause_t        wb_irq_cause_i,
  input  core_evt_pkg::dbg_cause_t        wb_dbg_cause_i,

  // Exception of the retiring instruction and step mode
  input  logic                            exc_i,
  input  core_evt_pkg::exc_cause_t        exc_cause_i,
  input  logic                            step_en_i,

  // Trace record
  output logic                            rvfi_valid_o,
  output logic                            rvfi_intr_o,
  output logic                            rvfi_intr_exc_o,
  output logic                            rvfi_intr_irq_o,
  output rvfi_trace_pkg::intr_cause_t     rvfi_intr_cause_o,
  output logic                            rvfi_trap_o,
  output logic                            rvfi_trap_exc_o,
  output logic                            rvfi_trap_dbg_o,
  output rvfi_trace_pkg::trap_cause_t     rvfi_trap_cause_o,
  output rvfi_trace_pkg::trap_dbg_cause_t rvfi_trap_dbg_cause_o,
  output rvfi_trace_pkg::dbg_field_t      rvfi_dbg_o
);

  // Events carried onto the next retirement
  logic                     pend_trap_q;
  logic                     pend_step_q;
  core_evt_pkg::exc_cause_t pend_cause_q;

  // Trap flags of the record
  rvfi_trace_pkg::trap_flags_t trap_d;
  rvfi_trace_pkg::trap_flags_t trap_q;

  rvfi_trace_pkg::trap_cause_t     trap_cause_d;
  rvfi_trace_pkg::trap_dbg_cause_t trap_dbg_cause_d;

  // Interrupt and debug fields of the record
  logic                        intr_d;
  logic                        intr_exc_d;
  logic                        intr_irq_d;
  rvfi_trace_pkg::intr_cause_t intr_cause_d;
  rvfi_trace_pkg::dbg_field_t  dbg_d;

  //////////////////////////////
  // Record fields
  //////////////////////////////

  // Trap describes the retiring instruction itself
  always_comb begin
    trap_d = '0;
    trap_d[rvfi_trace_pkg::TRAP_BIT_EXC]  = exc_i;
    trap_d[rvfi_trace_pkg::TRAP_BIT_DBG]  = step_en_i;
    trap_d[rvfi_trace_pkg::TRAP_BIT_TRAP] = exc_i || step_en_i;

    trap_cause_d     = exc_i ? exc_cause_i : '0;
    trap_dbg_cause_d = step_en_i ? core_evt_pkg::DBG_CAUSE_STEP
                                 : core_evt_pkg::DBG_CAUSE_NONE;
  end

  // The interrupt field reports how the retiring instruction was reached
  // A pending trap means it is the first handler instruction
  always_comb begin
    intr_d       = 1'b0;
    intr_exc_d   = 1'b0;
    intr_irq_d   = 1'b0;
    intr_cause_d = '0;
    if (pend_trap_q) begin
      intr_d       = 1'b1;
      intr_exc_d   = 1'b1;
      intr_cause_d = rvfi_trace_pkg::intr_cause_from_exc(pend_cause_q);
    end else if (wb_irq_i) begin
      intr_d       = 1'b1;
      intr_irq_d   = 1'b1;
      intr_cause_d = rvfi_trace_pkg::intr_cause_from_exc(wb_irq_cause_i);
    end
  end

  // Step entry after a stepped instruction overrides the marker cause
  assign dbg_d = pend_step_q ? core_evt_pkg::DBG_CAUSE_STEP : wb_dbg_cause_i;

  //////////////////////////////
  // Record registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o    <= 1'b0;
      rvfi_intr_o     <= 1'b0;
      rvfi_intr_exc_o <= 1'b0;
      rvfi_intr_irq_o <= 1'b0;
      trap_q          <= '0;
      rvfi_dbg_o      <= core_evt_pkg::DBG_CAUSE_NONE;
      pend_trap_q     <= 1'b0;
      pend_step_q     <= 1'b0;
    end else begin
      rvfi_valid_o <= wb_retire_i;
      if (wb_retire_i) begin
        rvfi_intr_o     <= intr_d;
        rvfi_intr_exc_o <= intr_exc_d;
        rvfi_intr_irq_o <= intr_irq_d;
        trap_q          <= trap_d;
        rvfi_dbg_o      <= dbg_d;
        // Consumed pending flags are replaced by this retirement's own events
        pend_trap_q     <= exc_i;
        pend_step_q     <= step_en_i;
      end else begin
        // flags only mean something while valid is high
        rvfi_intr_o     <= 1'b0;
        rvfi_intr_exc_o <= 1'b0;
        rvfi_intr_irq_o <= 1'b0;
        trap_q          <= '0;
        rvfi_dbg_o      <= core_evt_pkg::DBG_CAUSE_NONE;
      end
    end
  end

  // Causes hold their value until the next retirement
  // A check on the following record can still look back at them
  always_ff @(posedge clk_i) begin
    if (wb_retire_i) begin
      rvfi_intr_cause_o     <= intr_cause_d;
      rvfi_trap_cause_o     <= trap_cause_d;
      rvfi_trap_dbg_cause_o <= trap_dbg_cause_d;
    end
    if (wb_retire_i && exc_i) begin
      pend_cause_q <= exc_cause_i;
    end
  end

  assign rvfi_trap_o     = trap_q[rvfi_trace_pkg::TRAP_BIT_TRAP];
  assign rvfi_trap_exc_o = trap_q[rvfi_trace_pkg::TRAP_BIT_EXC];
  assign rvfi_trap_dbg_o = trap_q[rvfi_trace_pkg::TRAP_BIT_DBG];

endmodule

// File: hw/trace_stage_track.sv
module trace_stage_track (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Pipeline advance and fetch qualifier
  input  logic                     adv_i,
  input  logic                     fetch_valid_i,

  // Interrupt and debug acknowledges from the controller
  input  logic                     irq_ack_i,
  input  core_evt_pkg::exc_cause_t irq_cause_i,
  input  logic                     dbg_ack_i,
  input  core_evt_pkg::dbg_cause_t dbg_cause_i,
  input  logic                     ebreak_wb_i,

  // Marker of the instruction retiring from WB
  output logic                     wb_retire_o,
  output logic                     wb_irq_o,
  output core_evt_pkg::exc_cause_t wb_irq_cause_o,
  output core_evt_pkg::dbg_cause_t wb_dbg_cause_o
);

  // Valid bits of the registered stages ID to WB
  logic [core_evt_pkg::STAGE_WB:core_evt_pkg::STAGE_ID] valid_q;

  // Valid view over all four stages
  // The IF entry is the fetch qualifier itself
  logic [core_evt_pkg::NUM_STAGES-1:0] stage_valid;

  // Per-stage event markers
  logic [core_evt_pkg::NUM_STAGES-1:0] irq_q;
  core_evt_pkg::exc_cause_t            irq_cause_q [core_evt_pkg::NUM_STAGES];
  core_evt_pkg::dbg_cause_t            dbg_cause_q [core_evt_pkg::NUM_STAGES];

  // Marker currently waiting in IF
  logic                     in_trap_if_irq;
  core_evt_pkg::dbg_cause_t in_trap_if_dbg;

  // Next IF marker after hand-on and acknowledge merge
  logic                     if_irq_d;
  core_evt_pkg::exc_cause_t if_irq_cause_d;
  core_evt_pkg::dbg_cause_t if_dbg_cause_d;

  core_evt_pkg::dbg_cause_t dbg_cause_eff;
  logic                     if_hand_on;

  assign stage_valid[core_evt_pkg::STAGE_IF] = fetch_valid_i;
  assign stage_valid[core_evt_pkg::STAGE_WB:core_evt_pkg::STAGE_ID] = valid_q;

  assign in_trap_if_irq = irq_q[core_evt_pkg::STAGE_IF];
  assign in_trap_if_dbg = dbg_cause_q[core_evt_pkg::STAGE_IF];

  // An EBREAK in WB re-enters debug mode without a fresh cause from the controller
  assign dbg_cause_eff = ebreak_wb_i ? core_evt_pkg::DBG_CAUSE_EBREAK : dbg_cause_i;

  // The IF marker leaves with the first real instruction that moves on
  assign if_hand_on = adv_i && fetch_valid_i;

  //////////////////////////////
  // IF marker capture
  //////////////////////////////

  always_comb begin
    if_irq_d       = in_trap_if_irq;
    if_irq_cause_d = irq_cause_q[core_evt_pkg::STAGE_IF];
    if_dbg_cause_d = in_trap_if_dbg;

    // Marker handed to ID in this cycle so IF starts empty
    if (if_hand_on) begin
      if_irq_d       = 1'b0;
      if_irq_cause_d = '0;
      if_dbg_cause_d = core_evt_pkg::DBG_CAUSE_NONE;
    end

    // Fresh acknowledges land in IF even on a hand-on cycle
    // They merge with a waiting marker and the newest cause wins
    if (irq_ack_i) begin
      if_irq_d       = 1'b1;
      if_irq_cause_d = irq_cause_i;
    end
    if (dbg_ack_i) begin
      if_dbg_cause_d = dbg_cause_eff;
    end
  end

  //////////////////////////////
  // Stage shift
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      irq_q   <= '0;
      for (int s = 0; s < core_evt_pkg::NUM_STAGES; s++) begin
        irq_cause_q[s] <= '0;
        dbg_cause_q[s] <= core_evt_pkg::DBG_CAUSE_NONE;
      end
    end else begin
      // IF is updated every cycle since acknowledges do not wait for an advance
      irq_q[core_evt_pkg::STAGE_IF]       <= if_irq_d;
      irq_cause_q[core_evt_pkg::STAGE_IF] <= if_irq_cause_d;
      dbg_cause_q[core_evt_pkg::STAGE_IF] <= if_dbg_cause_d;

      if (adv_i) begin
        valid_q[core_evt_pkg::STAGE_ID] <= stage_valid[core_evt_pkg::STAGE_IF];
        valid_q[core_evt_pkg::STAGE_EX] <= stage_valid[core_evt_pkg::STAGE_ID];
        valid_q[core_evt_pkg::STAGE_WB] <= stage_valid[core_evt_pkg::STAGE_EX];

        // Markers only ride along with real instructions
        // A bubble moving down clears the marker of the slot it enters
        for (int s = core_evt_pkg::STAGE_ID; s < core_evt_pkg::NUM_STAGES; s++) begin
          irq_q[s] <= stage_valid[s-1] && irq_q[s-1];
          irq_cause_q[s] <= stage_valid[s-1] ? irq_cause_q[s-1] : '0;
          dbg_cause_q[s] <= stage_valid[s-1] ? dbg_cause_q[s-1]
                                             : core_evt_pkg::DBG_CAUSE_NONE;
        end
      end
    end
  end

  //////////////////////////////
  // WB view
  //////////////////////////////

  // Retirement needs a valid WB slot on an advance
  assign wb_retire_o    = stage_valid[core_evt_pkg::STAGE_WB] && adv_i;
  assign wb_irq_o       = irq_q[core_evt_pkg::STAGE_WB];
  assign wb_irq_cause_o = irq_cause_q[core_evt_pkg::STAGE_WB];
  assign wb_dbg_cause_o = dbg_cause_q[core_evt_pkg::STAGE_WB];

endmodule

// File: hw/trace_top.sv
module trace_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Core pipeline events
  input  logic                            adv_i,
  input  logic                            fetch_valid_i,
  input  logic                            irq_ack_i,
  input  core_evt_pkg::exc_cause_t        irq_cause_i,
  input  logic                            dbg_ack_i,
  input  core_evt_pkg::dbg_cause_t        dbg_cause_i,
  input  logic                            ebreak_wb_i,
  input  logic                            exc_i,
  input  core_evt_pkg::exc_cause_t        exc_cause_i,
  input  logic                            step_en_i,

  // Retirement trace
  output logic                            rvfi_valid_o,
  output logic                            rvfi_intr_o,
  output logic                            rvfi_intr_exc_o,
  output logic                            rvfi_intr_irq_o,
  output rvfi_trace_pkg::intr_cause_t     rvfi_intr_cause_o,
  output logic                            rvfi_trap_o,
  output logic                            rvfi_trap_exc_o,
  output logic                            rvfi_trap_dbg_o,
  output rvfi_trace_pkg::trap_cause_t     rvfi_trap_cause_o,
  output rvfi_trace_pkg::trap_dbg_cause_t rvfi_trap_dbg_cause_o,
  output rvfi_trace_pkg::dbg_field_t      rvfi_dbg_o
);

  // Marker of the instruction leaving WB
  logic                     wb_retire;
  logic                     wb_irq;
  core_evt_pkg::exc_cause_t wb_irq_cause;
  core_evt_pkg::dbg_cause_t wb_dbg_cause;

  //////////////////////////////
  // Marker tracking
  //////////////////////////////

  trace_stage_track u_track (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .adv_i          (adv_i),
    .fetch_valid_i  (fetch_valid_i),
    .irq_ack_i      (irq_ack_i),
    .irq_cause_i    (irq_cause_i),
    .dbg_ack_i      (dbg_ack_i),
    .dbg_cause_i    (dbg_cause_i),
    .ebreak_wb_i    (ebreak_wb_i),
    .wb_retire_o    (wb_retire),
    .wb_irq_o       (wb_irq),
    .wb_irq_cause_o (wb_irq_cause),
    .wb_dbg_cause_o (wb_dbg_cause)
  );

  //////////////////////////////
  // Record formatting
  //////////////////////////////

  // Exception and step inputs refer to the same WB instruction as wb_retire
  trace_retire_fmt u_fmt (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .wb_retire_i           (wb_retire),
    .wb_irq_i              (wb_irq),
    .wb_irq_cause_i        (wb_irq_cause),
    .wb_dbg_cause_i        (wb_dbg_cause),
    .exc_i                 (exc_i),
    .exc_cause_i           (exc_cause_i),
    .step_en_i             (step_en_i),
    .rvfi_valid_o          (rvfi_valid_o),
    .rvfi_intr_o           (rvfi_intr_o),
    .rvfi_intr_exc_o       (rvfi_intr_exc_o),
    .rvfi_intr_irq_o       (rvfi_intr_irq_o),
    .rvfi_intr_cause_o     (rvfi_intr_cause_o),
    .rvfi_trap_o           (rvfi_trap_o),
    .rvfi_trap_exc_o       (rvfi_trap_exc_o),
    .rvfi_trap_dbg_o       (rvfi_trap_dbg_o),
    .rvfi_trap_cause_o     (rvfi_trap_cause_o),
    .rvfi_trap_dbg_cause_o (rvfi_trap_dbg_cause_o),
    .rvfi_dbg_o            (rvfi_dbg_o)
  );

endmodule

// File: sim/trace_assert.sv
module trace_assert (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Core side events
  input  logic                            adv_i,
  input  logic                            fetch_valid_i,
  input  logic                            irq_ack_i,
  input  logic                            dbg_ack_i,
  input  core_evt_pkg::dbg_cause_t        dbg_cause_i,
  input  logic                            ebreak_wb_i,

  // Marker waiting in IF inside the tracker
  input  logic                            if_irq_i,
  input  core_evt_pkg::dbg_cause_t        if_dbg_i,

  // Trace record
  input  logic                            rvfi_valid_i,
  input  logic                            rvfi_intr_i,
  input  logic                            rvfi_intr_exc_i,
  input  logic                            rvfi_intr_irq_i,
  input  rvfi_trace_pkg::intr_cause_t     rvfi_intr_cause_i,
  input  logic                            rvfi_trap_i,
  input  logic                            rvfi_trap_exc_i,
  input  logic                            rvfi_trap_dbg_i,
  input  rvfi_trace_pkg::trap_cause_t     rvfi_trap_cause_i,
  input  rvfi_trace_pkg::trap_dbg_cause_t rvfi_trap_dbg_cause_i,
  input  rvfi_trace_pkg::dbg_field_t      rvfi_dbg_i
);

  int fail_cnt = 0;

  // Cause the controller really enters debug with
  core_evt_pkg::dbg_cause_t dbg_eff;
  logic                     dbg_open_inc;
  logic                     nonstep_dbg;

  // Debug entries acknowledged but not yet seen in a record
  logic [3:0] dbg_open_q;

  // Trap fields of the previous valid record
  logic                            trap_seen_q;
  rvfi_trace_pkg::trap_cause_t     trap_cause_seen_q;
  logic                            step_seen_q;
  rvfi_trace_pkg::trap_dbg_cause_t step_cause_seen_q;

  // Advances made by the oldest instruction since reset, saturating at four
  logic [2:0] oldest_adv_q;

  assign dbg_eff = ebreak_wb_i ? core_evt_pkg::DBG_CAUSE_EBREAK : dbg_cause_i;
  assign dbg_open_inc = dbg_ack_i && (dbg_eff != core_evt_pkg::DBG_CAUSE_NONE);
  assign nonstep_dbg = rvfi_valid_i && (rvfi_dbg_i != core_evt_pkg::DBG_CAUSE_NONE)
                       && (rvfi_dbg_i != core_evt_pkg::DBG_CAUSE_STEP);

  //////////////////////////////
  // Reference state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_open_q        <= '0;
      trap_seen_q       <= 1'b0;
      trap_cause_seen_q <= '0;
      step_seen_q       <= 1'b0;
      step_cause_seen_q <= core_evt_pkg::DBG_CAUSE_NONE;
      oldest_adv_q      <= '0;
    end else begin
      // Merged acknowledges leave the count too high, which is harmless here
      if (dbg_open_inc && !nonstep_dbg && (dbg_open_q != '1)) begin
        dbg_open_q <= dbg_open_q + 4'd1;
      end else if (nonstep_dbg && !dbg_open_inc && (dbg_open_q != '0)) begin
        dbg_open_q <= dbg_open_q - 4'd1;
      end
      if (rvfi_valid_i) begin
        trap_seen_q       <= rvfi_trap_exc_i;
        trap_cause_seen_q <= rvfi_trap_cause_i;
        step_seen_q       <= rvfi_trap_dbg_i;
        step_cause_seen_q <= rvfi_trap_dbg_cause_i;
      end
      // Counting starts with the first fetched instruction entering ID
      if (adv_i && (oldest_adv_q != 3'd4) && ((oldest_adv_q != 3'd0) || fetch_valid_i)) begin
        oldest_adv_q <= oldest_adv_q + 3'd1;
      end
    end
  end

  //////////////////////////////
  // Ordering rules
  //////////////////////////////

  a_irq_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> if_irq_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("IF irq marker missing after irq_ack_i");
    end

  a_dbg_capture: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack_i |=> (if_dbg_i == $past(dbg_eff)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("IF debug cause differs from acknowledge");
    end

  a_dbg_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nonstep_dbg |-> (dbg_open_q != '0))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Debug record without dbg_ack_i");
    end

  // The record after a trapped one is the first handler instruction
  a_trap_then_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && trap_seen_q) |-> (rvfi_intr_i && rvfi_intr_exc_i && !rvfi_intr_irq_i
      && (rvfi_intr_cause_i == rvfi_trace_pkg::intr_cause_t'(trap_cause_seen_q))))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Trap not followed by exception intr");
    end

  a_step_then_dbg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && step_seen_q) |-> (rvfi_dbg_i == step_cause_seen_q))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Debug trap cause not carried forward");
    end

  a_exc_step_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && rvfi_trap_exc_i && rvfi_trap_dbg_i)
      |-> (rvfi_trap_dbg_cause_i == core_evt_pkg::DBG_CAUSE_STEP))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Trapped step without step cause");
    end

  // The summary trap bit covers both exception and debug traps
  a_trap_summary: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i |-> (rvfi_trap_i == (rvfi_trap_exc_i || rvfi_trap_dbg_i)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Trap flag disagrees with exception and debug flags");
    end

  a_no_stray_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvfi_valid_i && !step_seen_q) |-> (rvfi_dbg_i != core_evt_pkg::DBG_CAUSE_STEP))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Step record without a step trap");
    end

  a_first_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (oldest_adv_q != 3'd4) |-> !rvfi_valid_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Record before four advances");
    end

endmodule

// File: sim/trace_tb.sv
module trace_tb;

  localparam int          CLK_HALF       = 20;
  localparam int          RESET_CYCLES   = 16;
  localparam int          STIM_CYCLES    = 3000;
  localparam int          DRAIN_CYCLES   = 12;
  // Stimulus length plus a third of it as slack for reset and drain
  localparam int          TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 3;
  localparam logic [31:0] SEED           = 32'h4103_d184;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            adv_i;
  logic                            fetch_valid_i;
  logic                            irq_ack_i;
  core_evt_pkg::exc_cause_t        irq_cause_i;
  logic                            dbg_ack_i;
  core_evt_pkg::dbg_cause_t        dbg_cause_i;
  logic                            ebreak_wb_i;
  logic                            exc_i;
  core_evt_pkg::exc_cause_t        exc_cause_i;
  logic                            step_en_i;
  logic                            rvfi_valid_o;
  logic                            rvfi_intr_o;
  logic                            rvfi_intr_exc_o;
  logic                            rvfi_intr_irq_o;
  rvfi_trace_pkg::intr_cause_t     rvfi_intr_cause_o;
  logic                            rvfi_trap_o;
  logic                            rvfi_trap_exc_o;
  logic                            rvfi_trap_dbg_o;
  rvfi_trace_pkg::trap_cause_t     rvfi_trap_cause_o;
  rvfi_trace_pkg::trap_dbg_cause_t rvfi_trap_dbg_cause_o;
  rvfi_trace_pkg::dbg_field_t      rvfi_dbg_o;

  int tb_err = 0;

  // Record kinds seen, so each assertion is known to have been reached
  int rec_cnt       = 0;
  int irq_rec_cnt   = 0;
  int exc_rec_cnt   = 0;
  int trap_rec_cnt  = 0;
  int halt_rec_cnt  = 0;
  int step_rec_cnt  = 0;
  int exc_step_cnt  = 0;

  trace_top DUT (.*);

  bind trace_top trace_assert u_assert (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .adv_i                 (adv_i),
    .fetch_valid_i         (fetch_valid_i),
    .irq_ack_i             (irq_ack_i),
    .dbg_ack_i             (dbg_ack_i),
    .dbg_cause_i           (dbg_cause_i),
    .ebreak_wb_i           (ebreak_wb_i),
    .if_irq_i              (u_track.in_trap_if_irq),
    .if_dbg_i              (u_track.in_trap_if_dbg),
    .rvfi_valid_i          (rvfi_valid_o),
    .rvfi_intr_i           (rvfi_intr_o),
    .rvfi_intr_exc_i       (rvfi_intr_exc_o),
    .rvfi_intr_irq_i       (rvfi_intr_irq_o),
    .rvfi_intr_cause_i     (rvfi_intr_cause_o),
    .rvfi_trap_i           (rvfi_trap_o),
    .rvfi_trap_exc_i       (rvfi_trap_exc_o),
    .rvfi_trap_dbg_i       (rvfi_trap_dbg_o),
    .rvfi_trap_cause_i     (rvfi_trap_cause_o),
    .rvfi_trap_dbg_cause_i (rvfi_trap_dbg_cause_o),
    .rvfi_dbg_i            (rvfi_dbg_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input int unsigned exp, input int unsigned act);
    if (exp != act) begin
      tb_err++;
      $display("CHECK FAILED at time %0t: %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_reached(input string what, input int cnt);
    if (cnt == 0) begin
      tb_err++;
      $display("Stimulus never produced %s", what);
    end
  endtask

  //////////////////////////////
  // Record classification
  //////////////////////////////

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni && rvfi_valid_o) begin
      rec_cnt++;
      if (rvfi_intr_irq_o) irq_rec_cnt++;
      if (rvfi_intr_exc_o) exc_rec_cnt++;
      if (rvfi_trap_exc_o) trap_rec_cnt++;
      if (rvfi_trap_exc_o && rvfi_trap_dbg_o) exc_step_cnt++;
      if (rvfi_dbg_o == core_evt_pkg::DBG_CAUSE_STEP) step_rec_cnt++;
      else if (rvfi_dbg_o != core_evt_pkg::DBG_CAUSE_NONE) halt_rec_cnt++;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int   step_left;
    logic adv;
    rst_ni        = 1'b0;
    adv_i         = 1'b0;
    fetch_valid_i = 1'b0;
    irq_ack_i     = 1'b0;
    irq_cause_i   = '0;
    dbg_ack_i     = 1'b0;
    dbg_cause_i   = core_evt_pkg::DBG_CAUSE_NONE;
    ebreak_wb_i   = 1'b0;
    exc_i         = 1'b0;
    exc_cause_i   = '0;
    step_en_i     = 1'b0;
    step_left     = 0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) @(negedge clk_i);
    check_value("rvfi_valid_o", 0, rvfi_valid_o);
    check_value("rvfi_intr_o", 0, rvfi_intr_o);
    check_value("rvfi_trap_o", 0, rvfi_trap_o);
    check_value("rvfi_dbg_o", 0, rvfi_dbg_o);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int c = 0; c < STIM_CYCLES; c++) begin
      @(posedge clk_i);
      adv = (($urandom % 100) < 60);
      adv_i         <= adv;
      fetch_valid_i <= (($urandom % 100) < 80);
      irq_ack_i     <= (($urandom % 100) < 5);
      irq_cause_i   <= core_evt_pkg::exc_cause_t'($urandom);
      dbg_ack_i     <= (($urandom % 100) < 5);
      // Only legal controller causes, step entry comes from the formatter
      dbg_cause_i   <= 1'($urandom) ? core_evt_pkg::DBG_CAUSE_HALTREQ
                                    : core_evt_pkg::DBG_CAUSE_EBREAK;
      ebreak_wb_i   <= 1'($urandom);
      exc_i         <= adv && (($urandom % 100) < 8);
      exc_cause_i   <= core_evt_pkg::exc_cause_t'($urandom);
      if (step_left == 0) begin
        step_en_i <= !step_en_i;
        step_left = 150 + ($urandom % 250);
      end else begin
        step_left--;
      end
    end

    @(posedge clk_i);
    adv_i     <= 1'b0;
    irq_ack_i <= 1'b0;
    dbg_ack_i <= 1'b0;
    exc_i     <= 1'b0;
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    check_value("rvfi_valid_o", 0, rvfi_valid_o);

    check_reached("an interrupt record", irq_rec_cnt);
    check_reached("a trapped record", trap_rec_cnt);
    check_reached("a record after a trap", exc_rec_cnt);
    check_reached("a halt or ebreak debug record", halt_rec_cnt);
    check_reached("a step debug record", step_rec_cnt);
    check_reached("a trapped record in step mode", exc_step_cnt);

    $display("Closing counts: %0d records, %0d assertion failures, %0d testbench errors",
             rec_cnt, DUT.u_assert.fail_cnt, tb_err);
    if ((DUT.u_assert.fail_cnt == 0) && (tb_err == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog on the total run length
  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
